//--- src/mul_pkg.sv
package mul_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int OPND_WIDTH = 16;               // Signed operand width.
    localparam int PROD_WIDTH = 2 * OPND_WIDTH;   // Full signed product width.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        OP_EXACT  = 2'd0,   // Exact signed product.
        OP_APPROX = 2'd1,   // Approximate signed product.
        OP_ERROR  = 2'd2    // Approximate minus exact.
    } mul_op_e;

endpackage

//--- src/bw_approx_mult.sv
`timescale 1ns/100ps

module bw_approx_mult (
    input  logic signed [mul_pkg::OPND_WIDTH-1:0] x,
    input  logic signed [mul_pkg::OPND_WIDTH-1:0] y,
    output logic        [mul_pkg::PROD_WIDTH-1:0] prod
);

    import mul_pkg::*;

    logic [OPND_WIDTH-1:0] pp [OPND_WIDTH];   // Baugh-Wooley rows, one per bit of x.
    logic [20:0]           cmp0;
    logic [20:0]           cmp1;
    logic [20:0]           cmp2;
    logic [20:0]           cmp3;
    logic [PROD_WIDTH-1:0] upper_sum;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Partial-product rows
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < OPND_WIDTH; i++) begin : g_row
        if (i < OPND_WIDTH - 1) begin : g_pos
            assign pp[i] = {~(y[OPND_WIDTH-1] & x[i]),
                            y[OPND_WIDTH-2:0] & {(OPND_WIDTH - 1){x[i]}}};
        end else begin : g_neg
            assign pp[i] = {y[OPND_WIDTH-1] & x[i],
                            ~(y[OPND_WIDTH-2:0] & {(OPND_WIDTH - 1){x[i]}})};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Approximate compression of rows 0 to 5
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        cmp0 = '0;
        cmp1 = '0;
        cmp2 = '0;
        cmp3 = '0;

        // Rows 0 and 1.
        cmp0[3]  = pp[0][3] & pp[1][2];     // Carry left in the sum column.
        cmp1[3]  = pp[0][3] ^ pp[1][2];
        cmp0[6]  = pp[0][6] ^ pp[1][5];     // Sum only, carry dropped.
        cmp0[9]  = pp[0][9] ^ pp[1][8];
        cmp0[11] = pp[0][11] ^ pp[1][10];
        cmp0[13] = pp[0][13] ^ pp[1][12];
        cmp0[15] = pp[0][15] ^ pp[1][14];
        cmp0[16] = pp[0][15] & pp[1][14];
        cmp0[17] = pp[1][15];
        cmp1[17] = 1'b1;                    // Stands in for the row 0 correction one.

        // Rows 2 and 3.
        cmp2[3]  = pp[2][1] ^ pp[3][0];
        cmp1[9]  = pp[2][6] & pp[3][5];
        cmp0[10] = pp[2][7] & pp[3][6];
        cmp1[10] = pp[2][8] ^ pp[3][7];
        cmp1[11] = pp[2][8] & pp[3][7];
        cmp0[12] = pp[2][9] & pp[3][8];
        cmp2[17] = pp[2][15] ^ pp[3][14];
        cmp0[18] = pp[2][15] & pp[3][14];
        cmp1[18] = pp[3][15];

        // Rows 4 and 5.
        cmp0[5]  = pp[4][1] ^ pp[5][0];
        cmp0[8]  = pp[4][3] & pp[5][2];
        cmp1[16] = pp[4][12] ^ pp[5][11];
        cmp3[17] = pp[4][13] ^ pp[5][12];
        cmp2[18] = pp[4][14] ^ pp[5][13];
        cmp0[19] = pp[4][14] & pp[5][13];
        cmp1[19] = pp[4][15] ^ pp[5][14];
        cmp0[20] = pp[4][15] & pp[5][14];
        cmp1[20] = pp[5][15];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Final summation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The top row carries the 2^31 correction one in its extra bit.
    always_comb begin
        upper_sum = {1'b1, pp[OPND_WIDTH-1], {(OPND_WIDTH - 1){1'b0}}};
        for (int i = 6; i < OPND_WIDTH - 1; i++) begin
            upper_sum = upper_sum + ({{OPND_WIDTH{1'b0}}, pp[i]} << i);
        end
    end

    assign prod = upper_sum
                + {11'b0, cmp0}
                + {11'b0, cmp1}
                + {11'b0, cmp2}
                + {11'b0, cmp3};

endmodule

//--- src/bw_exact_mult.sv
`timescale 1ns/100ps

module bw_exact_mult (
    input  logic signed [mul_pkg::OPND_WIDTH-1:0] x,
    input  logic signed [mul_pkg::OPND_WIDTH-1:0] y,
    output logic        [mul_pkg::PROD_WIDTH-1:0] prod
);

    import mul_pkg::*;

    logic [OPND_WIDTH-1:0] pp [OPND_WIDTH];
    logic [PROD_WIDTH-1:0] acc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Partial-product rows
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < OPND_WIDTH; i++) begin : g_row
        if (i < OPND_WIDTH - 1) begin : g_pos
            assign pp[i] = {~(y[OPND_WIDTH-1] & x[i]),
                            y[OPND_WIDTH-2:0] & {(OPND_WIDTH - 1){x[i]}}};
        end else begin : g_neg
            assign pp[i] = {y[OPND_WIDTH-1] & x[i],
                            ~(y[OPND_WIDTH-2:0] & {(OPND_WIDTH - 1){x[i]}})};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Full summation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // Start from the correction constant 2^31 + 2^16.
        acc = {1'b1, {(PROD_WIDTH - OPND_WIDTH - 2){1'b0}}, 1'b1, {OPND_WIDTH{1'b0}}};
        for (int i = 0; i < OPND_WIDTH; i++) begin
            acc = acc + ({{OPND_WIDTH{1'b0}}, pp[i]} << i);   // Row i sits at column i.
        end
    end

    assign prod = acc;   // Wraps modulo 2^32 to the signed product.

endmodule

//--- src/product_merge.sv
`timescale 1ns/100ps

module product_merge (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           in_valid,
    input  mul_pkg::mul_op_e               op,
    input  logic [mul_pkg::PROD_WIDTH-1:0] approx_prod,
    input  logic [mul_pkg::PROD_WIDTH-1:0] exact_prod,
    input  logic                           clr_max,
    output logic                           out_valid,
    output logic [mul_pkg::PROD_WIDTH-1:0] result,
    output logic [mul_pkg::PROD_WIDTH-1:0] max_err
);

    import mul_pkg::*;

    logic [PROD_WIDTH-1:0] err_diff;
    logic [PROD_WIDTH-1:0] err_mag;
    logic [PROD_WIDTH-1:0] sel_result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Error and result selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign err_diff = approx_prod - exact_prod;   // Two's complement difference.
    assign err_mag  = err_diff[PROD_WIDTH-1] ? (~err_diff + 1'b1) : err_diff;

    always_comb begin
        case (op)
            OP_EXACT:  sel_result = exact_prod;
            OP_APPROX: sel_result = approx_prod;
            OP_ERROR:  sel_result = err_diff;
            default:   sel_result = exact_prod;   // Unused encoding.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= in_valid;            // Exactly one cycle of latency.
            if (in_valid) begin
                result <= sel_result;         // Holds between operations.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Running maximum of the error magnitude
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            max_err <= '0;
        end else if (clr_max) begin
            max_err <= '0;                    // Clear takes priority over an update.
        end else if (in_valid && (err_mag > max_err)) begin
            max_err <= err_mag;
        end
    end

endmodule

//--- src/mul_unit_top.sv
`timescale 1ns/100ps

module mul_unit_top (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  in_valid,
    input  mul_pkg::mul_op_e                      op,
    input  logic signed [mul_pkg::OPND_WIDTH-1:0] x,
    input  logic signed [mul_pkg::OPND_WIDTH-1:0] y,
    input  logic                                  clr_max,
    output logic                                  out_valid,
    output logic        [mul_pkg::PROD_WIDTH-1:0] result,
    output logic        [mul_pkg::PROD_WIDTH-1:0] max_err
);

    import mul_pkg::*;

    logic [PROD_WIDTH-1:0] approx_prod;
    logic [PROD_WIDTH-1:0] exact_prod;

    // Both multipliers see the same operands in the same cycle.
    bw_approx_mult i_bw_approx_mult (
        .x    (x),
        .y    (y),
        .prod (approx_prod)
    );

    bw_exact_mult i_bw_exact_mult (
        .x    (x),
        .y    (y),
        .prod (exact_prod)
    );

    product_merge i_product_merge (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .op          (op),
        .approx_prod (approx_prod),
        .exact_prod  (exact_prod),
        .clr_max     (clr_max),
        .out_valid   (out_valid),
        .result      (result),
        .max_err     (max_err)
    );

endmodule

//--- dv/mul_unit_checker.sv
`timescale 1ns/100ps

module mul_unit_checker (
    input logic                                  clk,
    input logic                                  arst_n,
    input logic                                  in_valid,
    input mul_pkg::mul_op_e                      op,
    input logic signed [mul_pkg::OPND_WIDTH-1:0] x,
    input logic signed [mul_pkg::OPND_WIDTH-1:0] y,
    input logic                                  clr_max,
    input logic                                  out_valid,
    input logic        [mul_pkg::PROD_WIDTH-1:0] result,
    input logic        [mul_pkg::PROD_WIDTH-1:0] max_err
);

    import mul_pkg::*;

    localparam logic [PROD_WIDTH:0] ERR_LIMIT = 33'd8388608;   // 2^23 bounds every error.

    int fail_count = 0;

    logic                          first_cycle;
    logic                          prev_valid;
    mul_op_e                       prev_op;
    logic signed [OPND_WIDTH-1:0]  prev_x;
    logic signed [OPND_WIDTH-1:0]  prev_y;
    logic                          prev_clr;
    logic        [PROD_WIDTH-1:0]  prev_max;
    logic                          pair_armed;
    logic signed [OPND_WIDTH-1:0]  pair_x;
    logic signed [OPND_WIDTH-1:0]  pair_y;
    logic        [PROD_WIDTH-1:0]  pair_approx;
    logic signed [PROD_WIDTH-1:0]  true_prod;
    logic signed [PROD_WIDTH:0]    approx_dev;

    function automatic logic [PROD_WIDTH:0] magnitude(input logic signed [PROD_WIDTH:0] v);
        return v[PROD_WIDTH] ? -v : v;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One-cycle history of the sampled inputs and outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            first_cycle <= 1'b1;
            prev_valid  <= 1'b0;
            prev_op     <= OP_EXACT;
            prev_x      <= '0;
            prev_y      <= '0;
            prev_clr    <= 1'b0;
            prev_max    <= '0;
            pair_armed  <= 1'b0;
            pair_x      <= '0;
            pair_y      <= '0;
            pair_approx <= '0;
        end else begin
            first_cycle <= 1'b0;
            prev_valid  <= in_valid;
            prev_op     <= op;
            prev_x      <= x;
            prev_y      <= y;
            prev_clr    <= clr_max;
            prev_max    <= max_err;
            pair_armed  <= out_valid && (prev_op == OP_APPROX);   // Only the very next op pairs.
            if (out_valid && (prev_op == OP_APPROX)) begin
                pair_approx <= result;
                pair_x      <= prev_x;
                pair_y      <= prev_y;
            end
        end
    end

    assign true_prod  = prev_x * prev_y;
    assign approx_dev = $signed({result[PROD_WIDTH-1], result})
                      - $signed({true_prod[PROD_WIDTH-1], true_prod});

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_reset_state: assert property (@(posedge clk)
        first_cycle |-> (!out_valid && (result == '0) && (max_err == '0)))
        else begin
            fail_count++;
            $error("FAILED %0t out_valid/result/max_err expected 0/0/0 got %0b/%0h/%0h",
                   $time, out_valid, result, max_err);
        end

    a_valid_timing: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == prev_valid)
        else begin
            fail_count++;
            $error("FAILED %0t out_valid expected %0b got %0b", $time, prev_valid, out_valid);
        end

    a_exact: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && (prev_op == OP_EXACT)) |-> (result == true_prod))
        else begin
            fail_count++;
            $error("FAILED %0t result expected %0h got %0h", $time, true_prod, result);
        end

    a_approx_bound: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && (prev_op == OP_APPROX)) |-> (magnitude(approx_dev) < ERR_LIMIT))
        else begin
            fail_count++;
            $error("Approximate result %0h is too far from the product %0h", result, true_prod);
        end

    a_error_match: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && (prev_op == OP_ERROR) && pair_armed && (prev_x == pair_x)
         && (prev_y == pair_y)) |-> (result == pair_approx - true_prod))
        else begin
            fail_count++;
            $error("FAILED %0t result expected %0h got %0h", $time,
                   pair_approx - true_prod, result);
        end

    a_max_monotonic: assert property (@(posedge clk) disable iff (!arst_n)
        !prev_clr |-> (max_err >= prev_max))
        else begin
            fail_count++;
            $error("max_err decreased from %0h to %0h without a clear", prev_max, max_err);
        end

    a_max_covers: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && (prev_op == OP_ERROR) && !prev_clr)
        |-> ({1'b0, max_err} >= magnitude({result[PROD_WIDTH-1], result})))
        else begin
            fail_count++;
            $error("max_err %0h is below the error result %0h", max_err, result);
        end

    a_max_bound: assert property (@(posedge clk) disable iff (!arst_n)
        {1'b0, max_err} < ERR_LIMIT)
        else begin
            fail_count++;
            $error("max_err %0h is beyond the error limit", max_err);
        end

    a_max_clear: assert property (@(posedge clk) disable iff (!arst_n)
        prev_clr |-> (max_err == '0))
        else begin
            fail_count++;
            $error("FAILED %0t max_err expected 0 got %0h", $time, max_err);
        end

endmodule

//--- dv/mul_unit_tb.sv
`timescale 1ns/100ps

module mul_unit_tb;

    import mul_pkg::*;

    localparam int N_CORNER = 5;
    localparam int N_RAND   = 200;
    localparam int MAX_GAP  = 3;
    localparam int N_PAIR   = 40;
    localparam int DRAIN    = 2;
    // Reset test, corner products, random mix, pairs, then the clear sequence.
    localparam int RUN_CYCLES = (4 + 8) + (N_CORNER * N_CORNER + DRAIN)
                              + (N_RAND * (1 + MAX_GAP) + DRAIN)
                              + (2 * N_PAIR + DRAIN) + 16;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 100;

    logic                    clk;
    logic                    arst_n;
    logic                    in_valid;
    mul_op_e                 op;
    logic signed [15:0]      x;
    logic signed [15:0]      y;
    logic                    clr_max;
    logic                    out_valid;
    logic [PROD_WIDTH-1:0]   result;
    logic [PROD_WIDTH-1:0]   max_err;

    logic [31:0]             rng_state;
    int                      cycle_count;
    int                      tests_run;
    int                      fails_before;
    logic signed [15:0]      corners [N_CORNER];

    mul_unit_top i_mul_unit_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .x         (x),
        .y         (y),
        .clr_max   (clr_max),
        .out_valid (out_valid),
        .result    (result),
        .max_err   (max_err)
    );

    bind mul_unit_top mul_unit_checker i_mul_unit_checker (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int assertion_failures();
        return i_mul_unit_top.i_mul_unit_checker.fail_count;
    endfunction

    task automatic draw_operand(output logic signed [15:0] v);
        rng_state = lcg_step(rng_state);
        v = rng_state[31:16];   // Upper bits of the LCG are the most random.
    endtask

    task automatic draw_opcode(output mul_op_e code);
        rng_state = lcg_step(rng_state);
        case (rng_state[31:30])
            2'd0:    code = OP_EXACT;
            2'd1:    code = OP_APPROX;
            default: code = OP_ERROR;
        endcase
    endtask

    task automatic drive_op(input mul_op_e code, input logic signed [15:0] a,
                            input logic signed [15:0] b, input logic clear);
        @(negedge clk);
        in_valid = 1'b1;
        op       = code;
        x        = a;
        y        = b;
        clr_max  = clear;
    endtask

    task automatic idle_cycles(input int n, input logic clear);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            in_valid = 1'b0;
            clr_max  = clear;
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        idle_cycles(DRAIN, 1'b0);   // Lets the last result reach the checker.
        n = assertion_failures() - fails_before;
        $display("Test %s finished with %0d assertion failures", name, n);
        tests_run++;
        fails_before = assertion_failures();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock, timeout and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the stimulus did not complete", cycle_count);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic signed [15:0] a;
        logic signed [15:0] b;
        mul_op_e            code;
        int                 total;

        arst_n       = 1'b0;
        in_valid     = 1'b0;
        op           = OP_EXACT;
        x            = '0;
        y            = '0;
        clr_max      = 1'b0;
        rng_state    = 32'd5;
        tests_run    = 0;
        fails_before = 0;
        corners      = '{16'h0000, 16'h0001, 16'hFFFF, 16'h8000, 16'h7FFF};

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        idle_cycles(3, 1'b0);
        finish_test("reset");

        for (int i = 0; i < N_CORNER; i++) begin
            for (int j = 0; j < N_CORNER; j++) begin
                drive_op(OP_EXACT, corners[i], corners[j], 1'b0);
            end
        end
        finish_test("exact_corners");

        // Random gaps between operations give both bursts and idle stretches.
        for (int i = 0; i < N_RAND; i++) begin
            rng_state = lcg_step(rng_state);
            idle_cycles(int'(rng_state[31:30]), 1'b0);
            draw_opcode(code);
            draw_operand(a);
            draw_operand(b);
            drive_op(code, a, b, 1'b0);
        end
        finish_test("random_mix");

        for (int i = 0; i < N_PAIR; i++) begin
            if (i < N_CORNER) begin
                a = corners[i];
                b = corners[N_CORNER-1-i];
            end else begin
                draw_operand(a);
                draw_operand(b);
            end
            drive_op(OP_APPROX, a, b, 1'b0);
            drive_op(OP_ERROR, a, b, 1'b0);
        end
        finish_test("approx_error_pairs");

        for (int i = 0; i < 6; i++) begin
            draw_operand(a);
            draw_operand(b);
            drive_op(OP_ERROR, a, b, 1'b0);
        end
        drive_op(OP_ERROR, 16'h7FFF, 16'h003F, 1'b1);   // Clear together with a valid op.
        drive_op(OP_ERROR, 16'h7FFF, 16'h003F, 1'b0);
        idle_cycles(1, 1'b1);
        draw_operand(a);
        draw_operand(b);
        drive_op(OP_ERROR, a, b, 1'b0);
        finish_test("max_error_clear");

        total = assertion_failures();
        $display("Tests run: %0d, assertion failures: %0d", tests_run, total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- project.f
src/mul_pkg.sv
src/bw_approx_mult.sv
src/bw_exact_mult.sv
src/product_merge.sv
src/mul_unit_top.sv
dv/mul_unit_checker.sv
dv/mul_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --timing --assert -Wno-fatal
TOP        ?= mul_unit_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
RUN_FLAGS  ?= +verilator+error+limit+1000
FAIL_MSG   := Errors found
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
